// File: Makefile
# Verilator flow for the data TLB project

VERILATOR ?= verilator
TOP       ?= mmuTb
SEED      ?= 42083
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST  ?= verilog.f
PASS_MSG  := All checks passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary --timing --top-module $(TOP) -GSEED=$(SEED) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/dtlbStage.sv
`timescale 1ns/1ps
`include "mmuDefs.svh"

module dtlbStage (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  mmuPkg::memReq_t     req,
    input  mmuPkg::tlbLookup_t  lookup,
    output mmuPkg::memResp_t    resp
);

    import mmuPkg::*;

    typedef enum logic {
        IDLE,
        SEARCH
    } state_t;

    state_t state;
    state_t stateNext;

    logic [3:0]             segNibble;
    logic                   isKseg0;
    logic                   isKseg1;
    logic                   isMapped;
    logic                   access;
    logic                   mappedAccess;
    logic [VPN_W-1:0]       reqVpn;
    logic [`PAGE_OFS_W-1:0] pageOfs;

    logic                   bufFilled;
    logic [VPN_W-1:0]       bufVpn;
    logic [`ASID_W-1:0]     bufAsid;
    tlbLookup_t             bufData;
    logic                   bufHit;
    logic                   bufWe;

    logic                   stall;
    logic                   excCheck;
    tlbExc_t                exc;
    logic [VADDR_W-1:0]     paddr;
    logic                   uncached;
    logic                   accessOk;

    assign segNibble = req.vaddr[VADDR_W-1:VADDR_W-4];
    assign reqVpn    = req.vaddr[VADDR_W-1:`PAGE_OFS_W];
    assign pageOfs   = req.vaddr[`PAGE_OFS_W-1:0];

    always_comb begin
        isKseg0 = 1'b0;
        isKseg1 = 1'b0;
        case (segNibble)
            4'h8, 4'h9: isKseg0 = 1'b1;     // unmapped and cached
            4'hA, 4'hB: isKseg1 = 1'b1;     // unmapped and uncached
            default: ;
        endcase
    end

    assign isMapped     = !(isKseg0 || isKseg1);
    assign access       = req.read || req.store;
    assign mappedAccess = isMapped && access;

    // buffer tag match
    assign bufHit = bufFilled && (bufVpn == reqVpn) && (bufAsid == req.asid);
    assign stall  = mappedAccess && !bufHit;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (stall) begin
                    stateNext = SEARCH;
                end
            end
            SEARCH: stateNext = IDLE;       // buffer captured at this edge
            default: stateNext = IDLE;
        endcase
    end

    assign bufWe = (state == SEARCH) && mappedAccess;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            bufFilled <= 1'b0;
        end else if (bufWe) begin
            bufFilled <= 1'b1;
        end
    end

    // tag and array answer including not-found results
    always_ff @(posedge clk) begin
        if (bufWe) begin
            bufVpn  <= reqVpn;
            bufAsid <= req.asid;
            bufData <= lookup;
        end
    end

    always_comb begin
        if (isKseg1) begin
            paddr = {3'b000, req.vaddr[28:0]};
        end else if (isKseg0) begin
            paddr = {1'b0, req.vaddr[30:0]};
        end else begin
            paddr = {bufData.pfn, pageOfs};
        end
    end

    assign uncached = isKseg1 || (isMapped && bufHit && (bufData.c == C_UNCACHED));

    // only a mapped access that hits the buffer can fault
    assign excCheck = mappedAccess && bufHit;

    always_comb begin
        exc.rdRefill  = excCheck && req.read && !bufData.found;
        exc.wrRefill  = excCheck && req.store && !bufData.found;
        exc.rdInvalid = excCheck && req.read && bufData.found && !bufData.v;
        exc.wrInvalid = excCheck && req.store && bufData.found && !bufData.v;
        exc.modified  = excCheck && req.store && bufData.found && bufData.v
                        && !bufData.d;
    end

    assign accessOk = access && !stall && (exc == '0);

    always_comb begin
        resp.paddr    = paddr;
        resp.uncached = uncached;
        resp.stall    = stall;
        resp.accessOk = accessOk;
        resp.exc      = exc;
    end

endmodule

// File: source/mmuDefs.svh
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// data TLB geometry

`define TLB_ENTRIES 16

`define TLB_IDX_W 4       // log2 of TLB_ENTRIES

// address space identifier
`define ASID_W 4

// 4 KB pages
`define PAGE_OFS_W 12

`endif

// File: source/mmuPkg.sv
`include "mmuDefs.svh"

package mmuPkg;

    localparam int VADDR_W = 32;
    localparam int VPN_W = VADDR_W - `PAGE_OFS_W;
    localparam int PFN_W = 20;
    localparam logic [2:0] C_UNCACHED = 3'd2;     // cache attribute for uncached pages

    typedef struct packed {
        logic [VPN_W-1:0]   vpn;
        logic [`ASID_W-1:0] asid;
        logic               g;      // global entry ignores asid
        logic [PFN_W-1:0]   pfn;
        logic [2:0]         c;
        logic               d;      // dirty means writable
        logic               v;
    } tlbEntry_t;

    typedef struct packed {
        logic                  found;
        logic [`TLB_IDX_W-1:0] index;
        logic [PFN_W-1:0]      pfn;
        logic [2:0]            c;
        logic                  d;
        logic                  v;
    } tlbLookup_t;

    typedef struct packed {
        logic [VADDR_W-1:0] vaddr;
        logic [`ASID_W-1:0] asid;
        logic               read;
        logic               store;
    } memReq_t;

    typedef struct packed {
        logic rdRefill;
        logic wrRefill;
        logic rdInvalid;
        logic wrInvalid;
        logic modified;
    } tlbExc_t;

    typedef struct packed {
        logic [VADDR_W-1:0] paddr;
        logic               uncached;
        logic               stall;
        logic               accessOk;   // access may proceed this cycle
        tlbExc_t            exc;
    } memResp_t;

endpackage

// File: source/mmuTop.sv
`timescale 1ns/1ps
`include "mmuDefs.svh"

module mmuTop (
    input  logic                   clk,
    input  logic                   reset,
    input  mmuPkg::memReq_t        req,
    input  logic                   tlbWe,
    input  logic [`TLB_IDX_W-1:0]  tlbWIndex,
    input  mmuPkg::tlbEntry_t      tlbWEntry,
    output mmuPkg::memResp_t       resp
);

    import mmuPkg::*;

    tlbLookup_t       lookup;
    logic [VPN_W-1:0] reqVpn;

    assign reqVpn = req.vaddr[VADDR_W-1:`PAGE_OFS_W];

    tlbArray tlbArrayInst (
        .clk    (clk),
        .reset  (reset),
        .we     (tlbWe),
        .wIndex (tlbWIndex),
        .wEntry (tlbWEntry),
        .vpn    (reqVpn),
        .asid   (req.asid),
        .lookup (lookup)
    );

    // any TLB write empties the lookup buffer
    dtlbStage dtlbStageInst (
        .clk    (clk),
        .reset  (reset),
        .flush  (tlbWe),
        .req    (req),
        .lookup (lookup),
        .resp   (resp)
    );

endmodule

// File: source/tlbArray.sv
`timescale 1ns/1ps
`include "mmuDefs.svh"

module tlbArray (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      we,
    input  logic [`TLB_IDX_W-1:0]     wIndex,
    input  mmuPkg::tlbEntry_t         wEntry,
    input  logic [mmuPkg::VPN_W-1:0]  vpn,
    input  logic [`ASID_W-1:0]        asid,
    output mmuPkg::tlbLookup_t        lookup
);

    import mmuPkg::*;

    tlbEntry_t entries [`TLB_ENTRIES];

    logic [`TLB_ENTRIES-1:0] matchVec;
    logic                    hitAny;
    logic [`TLB_IDX_W-1:0]   hitIdx;
    tlbEntry_t               hitEntry;

    // entry storage
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                entries[i] <= '0;       // all invalid
            end
        end else if (we) begin
            entries[wIndex] <= wEntry;
        end
    end

    // parallel tag compare
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            matchVec[i] = (entries[i].vpn == vpn)
                          && (entries[i].g || (entries[i].asid == asid));
        end
    end

    // lowest matching entry wins
    always_comb begin
        hitAny = 1'b0;
        hitIdx = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (matchVec[i]) begin
                hitAny = 1'b1;
                hitIdx = `TLB_IDX_W'(i);
            end
        end
    end

    assign hitEntry = entries[hitIdx];

    // result fields are zero on a miss
    always_comb begin
        lookup = '0;
        if (hitAny) begin
            lookup.found = 1'b1;
            lookup.index = hitIdx;
            lookup.pfn   = hitEntry.pfn;
            lookup.c     = hitEntry.c;
            lookup.d     = hitEntry.d;
            lookup.v     = hitEntry.v;
        end
    end

endmodule

// File: verif/mmuRefModel.svh
`ifndef MMU_REF_MODEL_SVH
`define MMU_REF_MODEL_SVH

// shadow of the TLB contents and of the one-entry lookup buffer
tlbEntry_t          refEntries [`TLB_ENTRIES];
logic               refBufFilled;
logic [VPN_W-1:0]   refBufVpn;
logic [`ASID_W-1:0] refBufAsid;

function automatic void refReset();
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
        refEntries[i] = '0;
    end
    refBufFilled = 1'b0;
endfunction

function automatic void refWrite(input logic [`TLB_IDX_W-1:0] idx, input tlbEntry_t e);
    refEntries[idx] = e;
    refBufFilled = 1'b0;    // any write empties the buffer
endfunction

// stall cycles of one access and buffer shadow update
function automatic int refStallCycles(input memReq_t r);
    logic [VPN_W-1:0] vpn;
    vpn = r.vaddr[31:12];
    if (r.vaddr[31:30] == 2'b10 || !(r.read || r.store)) begin
        return 0;           // kseg0, kseg1 or no access
    end
    if (refBufFilled && refBufVpn == vpn && refBufAsid == r.asid) begin
        return 0;
    end
    refBufFilled = 1'b1;
    refBufVpn    = vpn;
    refBufAsid   = r.asid;
    return 2;
endfunction

// response once stall has fallen
function automatic memResp_t refTranslate(input memReq_t r);
    memResp_t  exp;
    logic      found;
    tlbEntry_t hit;
    exp   = '0;
    found = 1'b0;
    hit   = '0;
    if (r.vaddr[31:29] == 3'b100) begin
        exp.paddr = {1'b0, r.vaddr[30:0]};
    end else if (r.vaddr[31:29] == 3'b101) begin
        exp.paddr    = {3'b000, r.vaddr[28:0]};
        exp.uncached = 1'b1;
    end else begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (!found && refEntries[i].vpn == r.vaddr[31:12]
                && (refEntries[i].g || refEntries[i].asid == r.asid)) begin
                found = 1'b1;
                hit   = refEntries[i];
            end
        end
        exp.paddr         = {hit.pfn, r.vaddr[11:0]};   // pfn zero on a miss
        exp.uncached      = found && (hit.c == C_UNCACHED);
        exp.exc.rdRefill  = r.read && !found;
        exp.exc.wrRefill  = r.store && !found;
        exp.exc.rdInvalid = r.read && found && !hit.v;
        exp.exc.wrInvalid = r.store && found && !hit.v;
        exp.exc.modified  = r.store && found && hit.v && !hit.d;
    end
    exp.accessOk = (r.read || r.store) && (exp.exc == '0);
    return exp;
endfunction

`endif

// File: verif/mmuTb.sv
`timescale 1ns/1ps
`include "mmuDefs.svh"

module mmuTb #(
    parameter int SEED = 32'ha463
);

    import mmuPkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int N_UNMAPPED   = 16;
    localparam int N_MAPPED     = 8;
    localparam int N_REFILL     = 8;
    localparam int N_ACCESSES   = 1 + N_UNMAPPED + 3 * N_MAPPED + N_REFILL + 5 + 4 + 2;
    localparam int N_WRITES     = N_MAPPED + 4 + 1;
    localparam int TIMEOUT_CYCLES = N_ACCESSES * 4 + RESET_CYCLES + N_WRITES * 2 + 50;
    localparam logic [`ASID_W-1:0] MAIN_ASID = 4'h3;

    logic                  clk;
    logic                  reset;
    memReq_t               req;
    logic                  tlbWe;
    logic [`TLB_IDX_W-1:0] tlbWIndex;
    tlbEntry_t             tlbWEntry;
    memResp_t              resp;

    int       seed;
    int       checkCount = 0;
    int       errorCount = 0;
    int       cycleCount = 0;
    int       testChkBase;
    int       testErrBase;
    string    curTest;
    string    accName;
    logic     checkPending = 1'b0;  // stimulus to compare process
    memResp_t expResp;
    int       expStall;

    `include "mmuRefModel.svh"

    mmuTop dut_i (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .tlbWe     (tlbWe),
        .tlbWIndex (tlbWIndex),
        .tlbWEntry (tlbWEntry),
        .resp      (resp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout: the DUT gave no result within %0d cycles", cycleCount);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic checkResp(input string name, input memResp_t exp, input memResp_t act);
        checkCount++;
        if (act.paddr !== exp.paddr || act.uncached !== exp.uncached
            || act.accessOk !== exp.accessOk) begin
            errorCount++;
            $display("MISMATCH %s resp: expected %h/%b/%b, actual %h/%b/%b",
                     name, exp.paddr, exp.uncached, exp.accessOk,
                     act.paddr, act.uncached, act.accessOk);
        end
    endtask

    task automatic checkExc(input string name, input tlbExc_t exp, input tlbExc_t act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("MISMATCH %s exc: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic checkStall(input string name, input int exp, input int act);
        checkCount++;
        if (act != exp) begin
            errorCount++;
            $display("MISMATCH %s stall cycles: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // waits out the stall, then compares
    initial begin : compareProc
        int stallCycles;
        forever begin
            wait (checkPending);
            stallCycles = 0;
            @(negedge clk);
            while (resp.stall !== 1'b0) begin
                stallCycles++;
                @(negedge clk);
            end
            checkStall(accName, expStall, stallCycles);
            checkResp(accName, expResp, resp);
            checkExc(accName, expResp.exc, resp.exc);
            checkPending = 1'b0;
        end
    end

    function automatic memReq_t makeReq(input logic [31:0] vaddr,
                                        input logic [`ASID_W-1:0] asid, input logic isStore);
        memReq_t r;
        r.vaddr = vaddr;
        r.asid  = asid;
        r.read  = !isStore;
        r.store = isStore;
        return r;
    endfunction

    // kuseg vpn whose low nibble keeps entries apart
    function automatic tlbEntry_t randomEntry(input logic [3:0] tag,
                                              input logic [`ASID_W-1:0] asid,
                                              input logic g, input logic d, input logic v);
        tlbEntry_t   e;
        logic [31:0] rndA;
        logic [31:0] rndB;
        rndA   = $random(seed);
        rndB   = $random(seed);
        e.vpn  = {1'b0, rndA[14:0], tag};
        e.asid = asid;
        e.g    = g;
        e.pfn  = rndB[19:0];
        e.c    = tag[0] ? C_UNCACHED : rndB[22:20];
        e.d    = d;
        e.v    = v;
        return e;
    endfunction

    task automatic writeEntry(input logic [`TLB_IDX_W-1:0] idx, input tlbEntry_t e);
        @(posedge clk);
        req       <= '0;    // no access while the array changes
        tlbWe     <= 1'b1;
        tlbWIndex <= idx;
        tlbWEntry <= e;
        @(posedge clk);
        tlbWe <= 1'b0;
        refWrite(idx, e);
    endtask

    task automatic accessCheck(input string label, input memReq_t r);
        @(posedge clk);
        req <= r;
        expResp  = refTranslate(r);
        expStall = refStallCycles(r);
        accName  = {curTest, "/", label};
        checkPending = 1'b1;
        wait (!checkPending);
    endtask

    task automatic startTest(input string name);
        curTest     = name;
        testChkBase = checkCount;
        testErrBase = errorCount;
    endtask

    task automatic finishTest();
        $display("test %s: %0d checks, %0d errors", curTest,
                 checkCount - testChkBase, errorCount - testErrBase);
    endtask

    initial begin : stimulus
        tlbEntry_t   e;
        memReq_t     r;
        logic [31:0] rnd;
        seed      = SEED;
        reset     = 1'b1;
        req       = '0;
        tlbWe     = 1'b0;
        tlbWIndex = '0;
        tlbWEntry = '0;
        refReset();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        startTest("reset");
        @(negedge clk);
        checkStall("reset/idle", 0, (resp.stall !== 1'b0) ? 1 : 0);
        checkExc("reset/idle", '0, resp.exc);
        finishTest();

        startTest("unmapped");
        for (int i = 0; i < N_UNMAPPED; i++) begin
            rnd = $random(seed);
            r = makeReq({(i % 2 == 0) ? 3'b100 : 3'b101, rnd[28:0]}, rnd[3:0], rnd[29]);
            accessCheck($sformatf("kseg%0d_%0d", i % 2, i), r);
        end
        finishTest();

        startTest("mapped");
        for (int i = 0; i < N_MAPPED; i++) begin
            e = randomEntry(4'(i), MAIN_ASID, 1'b0, 1'b1, 1'b1);
            writeEntry(4'(i), e);
        end
        for (int i = 0; i < N_MAPPED; i++) begin
            rnd = $random(seed);
            r = makeReq({refEntries[i].vpn, rnd[11:0]}, MAIN_ASID, 1'b0);
            accessCheck($sformatf("miss%0d", i), r);
            r.vaddr[11:0] = rnd[23:12];
            accessCheck($sformatf("hit%0d", i), r);
            r.read  = 1'b0;
            r.store = 1'b1;
            accessCheck($sformatf("store%0d", i), r);
        end
        finishTest();

        startTest("refill");
        for (int i = 0; i < N_REFILL; i++) begin
            rnd = $random(seed);
            r = makeReq({2'b11, rnd[29:0]}, MAIN_ASID, (i % 2) == 1);   // kseg2/3 with no entry
            accessCheck($sformatf("noPage%0d", i), r);
        end
        e = randomEntry(4'h8, 4'h5, 1'b0, 1'b1, 1'b1);
        writeEntry(4'h8, e);
        accessCheck("otherAsidRd", makeReq({e.vpn, 12'h123}, 4'h6, 1'b0));
        accessCheck("otherAsidWr", makeReq({e.vpn, 12'h456}, 4'h6, 1'b1));
        accessCheck("ownAsidRd", makeReq({e.vpn, 12'h789}, 4'h5, 1'b0));
        e = randomEntry(4'h9, 4'h1, 1'b1, 1'b1, 1'b1);
        writeEntry(4'h9, e);
        accessCheck("globalRd", makeReq({e.vpn, 12'hABC}, 4'hE, 1'b0));
        accessCheck("globalWr", makeReq({e.vpn, 12'hDEF}, 4'h2, 1'b1));
        finishTest();

        startTest("invalid");
        e = randomEntry(4'hA, MAIN_ASID, 1'b0, 1'b1, 1'b0);
        writeEntry(4'hA, e);
        accessCheck("invalidRd", makeReq({e.vpn, 12'h010}, MAIN_ASID, 1'b0));
        accessCheck("invalidWr", makeReq({e.vpn, 12'h020}, MAIN_ASID, 1'b1));
        e = randomEntry(4'hB, MAIN_ASID, 1'b0, 1'b0, 1'b1);
        writeEntry(4'hB, e);
        accessCheck("cleanWr", makeReq({e.vpn, 12'h030}, MAIN_ASID, 1'b1));
        accessCheck("cleanRd", makeReq({e.vpn, 12'h040}, MAIN_ASID, 1'b0));
        finishTest();

        startTest("rewrite");
        r = makeReq({refEntries[0].vpn, 12'h5A4}, MAIN_ASID, 1'b0);
        accessCheck("before", r);
        e = refEntries[0];
        e.pfn = ~e.pfn;
        writeEntry(4'h0, e);
        accessCheck("after", r);
        finishTest();

        $display("summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+source
+incdir+verif
source/mmuPkg.sv
source/tlbArray.sv
source/dtlbStage.sv
source/mmuTop.sv
verif/mmuTb.sv
